//--- hw/csr_pkg.sv
package csr_pkg;

  localparam int CSR_ADDR_W = 14;
  localparam int XLEN       = 32;
  localparam int CNT_W      = 64;
  localparam int NUM_CSR    = 16;

  typedef logic [CSR_ADDR_W-1:0]      csr_addr_t;
  typedef logic [XLEN-1:0]            csr_data_t;
  typedef logic [$clog2(NUM_CSR)-1:0] csr_idx_t;  // Slot inside the bank

  // Basic and exception registers
  localparam csr_addr_t CSR_CRMD   = 14'h000;
  localparam csr_addr_t CSR_PRMD   = 14'h001;
  localparam csr_addr_t CSR_EUEN   = 14'h002;
  localparam csr_addr_t CSR_ECTL   = 14'h004;
  localparam csr_addr_t CSR_ESTAT  = 14'h005;
  localparam csr_addr_t CSR_ERA    = 14'h006;
  localparam csr_addr_t CSR_BADV   = 14'h007;
  localparam csr_addr_t CSR_EENTRY = 14'h00c;

  // Scratch
  localparam csr_addr_t CSR_SAVE0  = 14'h030;
  localparam csr_addr_t CSR_SAVE1  = 14'h031;
  localparam csr_addr_t CSR_SAVE2  = 14'h032;
  localparam csr_addr_t CSR_SAVE3  = 14'h033;

  // Timer group
  localparam csr_addr_t CSR_TID    = 14'h040;
  localparam csr_addr_t CSR_TCFG   = 14'h041;
  localparam csr_addr_t CSR_TVAL   = 14'h042;
  localparam csr_addr_t CSR_TICLR  = 14'h044;

  // Counter-read opcode from decode
  typedef logic [1:0] rdcnt_t;

  localparam rdcnt_t RDCNT_NONE  = 2'd0;  // Plain CSR read
  localparam rdcnt_t RDCNT_ID    = 2'd1;
  localparam rdcnt_t RDCNT_VLOW  = 2'd2;
  localparam rdcnt_t RDCNT_VHIGH = 2'd3;

endpackage

//--- hw/csr_reg_bank.sv
module csr_reg_bank (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               stall_i,
  input  logic               we_i,
  input  logic               commit_i,
  input  logic               valid_i,
  input  csr_pkg::csr_addr_t w_addr_i,
  input  csr_pkg::csr_data_t w_mask_i,
  input  csr_pkg::csr_data_t w_data_i,
  input  csr_pkg::csr_addr_t r_addr_i,
  output csr_pkg::csr_data_t rd_data_o,
  output csr_pkg::csr_data_t tid_o
);

  // Architectural address held in each bank slot
  function automatic csr_pkg::csr_addr_t slot_addr(input csr_pkg::csr_idx_t idx);
    csr_pkg::csr_addr_t a;
    case (idx)
      4'd0:  a = csr_pkg::CSR_CRMD;
      4'd1:  a = csr_pkg::CSR_PRMD;
      4'd2:  a = csr_pkg::CSR_EUEN;
      4'd3:  a = csr_pkg::CSR_ECTL;
      4'd4:  a = csr_pkg::CSR_ESTAT;
      4'd5:  a = csr_pkg::CSR_ERA;
      4'd6:  a = csr_pkg::CSR_BADV;
      4'd7:  a = csr_pkg::CSR_EENTRY;
      4'd8:  a = csr_pkg::CSR_SAVE0;
      4'd9:  a = csr_pkg::CSR_SAVE1;
      4'd10: a = csr_pkg::CSR_SAVE2;
      4'd11: a = csr_pkg::CSR_SAVE3;
      4'd12: a = csr_pkg::CSR_TID;
      4'd13: a = csr_pkg::CSR_TCFG;
      4'd14: a = csr_pkg::CSR_TVAL;
      4'd15: a = csr_pkg::CSR_TICLR;
    endcase
    return a;
  endfunction

  csr_pkg::csr_data_t          csr_q [csr_pkg::NUM_CSR];
  logic [csr_pkg::NUM_CSR-1:0] wr_en;
  logic                        wr_commit;

  // Only a committing, valid, unstalled instruction writes
  assign wr_commit = we_i && commit_i && valid_i && !stall_i;

  // Each slot decodes its own full 14-bit address
  always_comb begin
    for (int i = 0; i < csr_pkg::NUM_CSR; i++) begin
      wr_en[i] = wr_commit && (w_addr_i == slot_addr(csr_pkg::csr_idx_t'(i)));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < csr_pkg::NUM_CSR; i++) begin
        csr_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < csr_pkg::NUM_CSR; i++) begin
        if (wr_en[i]) begin
          // Set mask bit takes new data, clear bit keeps old
          csr_q[i] <= (csr_q[i] & ~w_mask_i) | (w_data_i & w_mask_i);
        end
      end
    end
  end

  always_comb begin
    rd_data_o = '0;  // Unmapped reads as zero
    tid_o     = '0;
    for (int i = 0; i < csr_pkg::NUM_CSR; i++) begin
      if (r_addr_i == slot_addr(csr_pkg::csr_idx_t'(i))) begin
        rd_data_o = csr_q[i];
      end
      if (slot_addr(csr_pkg::csr_idx_t'(i)) == csr_pkg::CSR_TID) begin
        tid_o = csr_q[i];  // Live TID for RDCNTID
      end
    end
  end

  // Two slots never answer the same write address
  a_one_write: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(wr_en))
    else $error("csr_reg_bank: more than one CSR write enable");

endmodule

//--- hw/stable_counter.sv
module stable_counter (
  input  logic                      clk,
  input  logic                      rst_n,
  output logic [csr_pkg::CNT_W-1:0] cnt_o
);

  logic [csr_pkg::CNT_W-1:0] cnt_q;

  // Free running, wraps at 2^64
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + csr_pkg::CNT_W'(1);
    end
  end

  assign cnt_o = cnt_q;

  // Step of exactly one per cycle once out of reset
  a_cnt_step: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> cnt_o == $past(cnt_o) + csr_pkg::CNT_W'(1))
    else $error("stable_counter: counter skipped or stalled");

endmodule

//--- hw/csr_read_select.sv
module csr_read_select (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      stall_i,
  input  csr_pkg::rdcnt_t           rdcnt_i,
  input  csr_pkg::csr_data_t        bank_rd_data_i,
  input  csr_pkg::csr_data_t        tid_i,
  input  logic [csr_pkg::CNT_W-1:0] cnt_i,
  output csr_pkg::csr_data_t        r_data_o
);

  csr_pkg::csr_data_t sel_data;
  csr_pkg::csr_data_t cnt_low;
  csr_pkg::csr_data_t cnt_high;
  csr_pkg::csr_data_t r_data_q;

  assign cnt_low  = cnt_i[csr_pkg::XLEN-1:0];
  assign cnt_high = cnt_i[csr_pkg::CNT_W-1 -: csr_pkg::XLEN];

  // Counter reads win over the CSR address
  always_comb begin
    case (rdcnt_i)
      csr_pkg::RDCNT_ID: begin
        sel_data = tid_i;
      end
      csr_pkg::RDCNT_VLOW: begin
        sel_data = cnt_low;
      end
      csr_pkg::RDCNT_VHIGH: begin
        sel_data = cnt_high;
      end
      default: begin
        sel_data = bank_rd_data_i;  // RDCNT_NONE
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_data_q <= '0;
    end else if (!stall_i) begin
      r_data_q <= sel_data;
    end
  end

  assign r_data_o = r_data_q;

  // Stall freezes the read result seen by the pipeline
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stall_i |=> $stable(r_data_o))
    else $error("csr_read_select: read data moved under stall");

endmodule

//--- hw/csr_unit.sv
module csr_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               stall_i,
  input  logic               we_i,
  input  logic               commit_i,
  input  logic               valid_i,
  input  csr_pkg::csr_addr_t w_addr_i,
  input  csr_pkg::csr_addr_t r_addr_i,
  input  csr_pkg::csr_data_t w_mask_i,
  input  csr_pkg::csr_data_t w_data_i,
  input  csr_pkg::rdcnt_t    rdcnt_i,
  output csr_pkg::csr_data_t r_data_o
);

  csr_pkg::csr_data_t        bank_rd_data;
  csr_pkg::csr_data_t        tid;
  logic [csr_pkg::CNT_W-1:0] cnt_value;

  csr_reg_bank i_reg_bank (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall_i   (stall_i),
    .we_i      (we_i),
    .commit_i  (commit_i),
    .valid_i   (valid_i),
    .w_addr_i  (w_addr_i),
    .w_mask_i  (w_mask_i),
    .w_data_i  (w_data_i),
    .r_addr_i  (r_addr_i),
    .rd_data_o (bank_rd_data),
    .tid_o     (tid)
  );

  // Stable counter for RDCNTVL and RDCNTVH
  stable_counter i_stable_counter (
    .clk   (clk),
    .rst_n (rst_n),
    .cnt_o (cnt_value)
  );

  csr_read_select i_read_select (
    .clk            (clk),
    .rst_n          (rst_n),
    .stall_i        (stall_i),
    .rdcnt_i        (rdcnt_i),
    .bank_rd_data_i (bank_rd_data),
    .tid_i          (tid),
    .cnt_i          (cnt_value),
    .r_data_o       (r_data_o)
  );

endmodule

//--- include/tb_csr_tasks.svh
`ifndef TB_CSR_TASKS_SVH
`define TB_CSR_TASKS_SVH

task automatic check_value(input string name, input csr_pkg::csr_data_t actual,
                           input csr_pkg::csr_data_t expected);
  if (actual !== expected) begin
    error_count++;
    $display("FAILED %s: actual 0x%08h, expected 0x%08h", name, actual, expected);
    $display("Finished with errors");
    $fatal(1, "Stopping at the first mismatch");
  end
endtask

task automatic reset_values_read_zero();
  csr_pkg::csr_data_t got;
  for (int i = 0; i < csr_pkg::NUM_CSR; i++) begin
    read_csr(csr_list[i], got);
    check_value("r_data_o (reset value)", got, '0);
  end
  read_csr(14'h100, got);
  check_value("r_data_o (unmapped)", got, '0);
endtask

task automatic write_readback();
  csr_pkg::csr_data_t got;
  csr_pkg::csr_data_t data;
  for (int i = 0; i < csr_pkg::NUM_CSR; i++) begin
    data = $random(seed);
    write_csr(csr_list[i], '1, data, 1'b1, 1'b1, 1'b0);
    model[i] = data;
    read_csr(csr_list[i], got);
    check_value("r_data_o (full write)", got, model[i]);
  end
  data = $random(seed);
  write_csr(14'h100, '1, data, 1'b1, 1'b1, 1'b0);  // Must not land anywhere
  for (int i = 0; i < csr_pkg::NUM_CSR; i++) begin
    read_csr(csr_list[i], got);
    check_value("r_data_o (after unmapped write)", got, model[i]);
  end
endtask

task automatic masked_write();
  csr_pkg::csr_data_t got;
  csr_pkg::csr_data_t data;
  csr_pkg::csr_data_t mask;
  mask = 32'h0f0f_00ff;
  data = $random(seed);
  r_addr = csr_pkg::CSR_SAVE1;
  rdcnt  = csr_pkg::RDCNT_NONE;
  write_csr(csr_pkg::CSR_SAVE1, mask, data, 1'b1, 1'b1, 1'b0);
  check_value("r_data_o (read during write)", r_data, model[SAVE1_SLOT]);
  for (int b = 0; b < csr_pkg::XLEN; b++) begin
    if (mask[b]) begin
      model[SAVE1_SLOT][b] = data[b];  // Masked bits take the new data
    end
  end
  read_csr(csr_pkg::CSR_SAVE1, got);
  check_value("r_data_o (masked write)", got, model[SAVE1_SLOT]);

  // Each blocked write leaves SAVE1 alone
  write_csr(csr_pkg::CSR_SAVE1, '1, ~model[SAVE1_SLOT], 1'b0, 1'b1, 1'b0);
  read_csr(csr_pkg::CSR_SAVE1, got);
  check_value("r_data_o (commit low)", got, model[SAVE1_SLOT]);
  write_csr(csr_pkg::CSR_SAVE1, '1, ~model[SAVE1_SLOT], 1'b1, 1'b0, 1'b0);
  read_csr(csr_pkg::CSR_SAVE1, got);
  check_value("r_data_o (valid low)", got, model[SAVE1_SLOT]);
  write_csr(csr_pkg::CSR_SAVE1, '1, ~model[SAVE1_SLOT], 1'b1, 1'b1, 1'b1);
  read_csr(csr_pkg::CSR_SAVE1, got);
  check_value("r_data_o (stall high)", got, model[SAVE1_SLOT]);
endtask

task automatic stall_holds_read();
  csr_pkg::csr_data_t held;
  read_csr(csr_pkg::CSR_SAVE0, held);
  check_value("r_data_o (before stall)", held, model[SAVE0_SLOT]);
  stall  = 1'b1;
  r_addr = csr_pkg::CSR_SAVE2;
  rdcnt  = csr_pkg::RDCNT_VLOW;
  next_cycle();
  check_value("r_data_o (stalled, VLOW)", r_data, held);
  rdcnt = csr_pkg::RDCNT_ID;
  next_cycle();
  check_value("r_data_o (stalled, ID)", r_data, held);
  rdcnt = csr_pkg::RDCNT_NONE;
  next_cycle();
  check_value("r_data_o (stalled, SAVE2)", r_data, held);
  stall = 1'b0;  // SAVE2 request still pending
  next_cycle();
  check_value("r_data_o (after stall)", r_data, model[SAVE2_SLOT]);
endtask

task automatic counter_reads();
  csr_pkg::csr_data_t tid_val;
  csr_pkg::csr_data_t low_a;
  csr_pkg::csr_data_t low_b;
  tid_val = $random(seed);
  write_csr(csr_pkg::CSR_TID, '1, tid_val, 1'b1, 1'b1, 1'b0);
  model[TID_SLOT] = tid_val;
  r_addr = csr_pkg::CSR_SAVE0;  // Ignored while rdcnt is set
  rdcnt  = csr_pkg::RDCNT_ID;
  next_cycle();
  check_value("r_data_o (RDCNTID)", r_data, model[TID_SLOT]);
  rdcnt = csr_pkg::RDCNT_VLOW;
  next_cycle();
  low_a = r_data;
  repeat (CNT_GAP) next_cycle();
  low_b = r_data;
  check_value("r_data_o (RDCNTVL delta)", low_b - low_a, CNT_GAP);
  rdcnt = csr_pkg::RDCNT_VHIGH;
  next_cycle();
  check_value("r_data_o (RDCNTVH)", r_data, '0);  // Short run never reaches 2^32
  rdcnt = csr_pkg::RDCNT_NONE;
endtask

`endif

//--- testbench/tb_csr_unit.sv
module tb_csr_unit;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;
  localparam int RESET_CYCLES = 8;
  localparam int CNT_GAP      = 7;

  // Rough cycle budget of each directed test
  localparam int T_RESET_READ = 17;
  localparam int T_WRITE_READ = 50;
  localparam int T_MASKED     = 12;
  localparam int T_STALL      = 5;
  localparam int T_COUNTER    = 4 + CNT_GAP;
  localparam int T_MARGIN     = 100;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + T_RESET_READ + T_WRITE_READ + T_MASKED
                                  + T_STALL + T_COUNTER + T_MARGIN;

  // Slots of the model array, in architectural listing order
  localparam int SAVE0_SLOT = 8;
  localparam int SAVE1_SLOT = 9;
  localparam int SAVE2_SLOT = 10;
  localparam int TID_SLOT   = 12;

  logic               clk;
  logic               rst_n;
  logic               stall;
  logic               we;
  logic               commit;
  logic               valid;
  csr_pkg::csr_addr_t w_addr;
  csr_pkg::csr_addr_t r_addr;
  csr_pkg::csr_data_t w_mask;
  csr_pkg::csr_data_t w_data;
  csr_pkg::rdcnt_t    rdcnt;
  csr_pkg::csr_data_t r_data;

  csr_pkg::csr_addr_t csr_list [csr_pkg::NUM_CSR];
  csr_pkg::csr_data_t model    [csr_pkg::NUM_CSR];  // Expected CSR contents
  integer             seed;
  int                 error_count;

  csr_unit i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall_i  (stall),
    .we_i     (we),
    .commit_i (commit),
    .valid_i  (valid),
    .w_addr_i (w_addr),
    .r_addr_i (r_addr),
    .w_mask_i (w_mask),
    .w_data_i (w_data),
    .rdcnt_i  (rdcnt),
    .r_data_o (r_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // Inputs change a little after each rising edge
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic load_csr_list();
    csr_list[0]  = csr_pkg::CSR_CRMD;
    csr_list[1]  = csr_pkg::CSR_PRMD;
    csr_list[2]  = csr_pkg::CSR_EUEN;
    csr_list[3]  = csr_pkg::CSR_ECTL;
    csr_list[4]  = csr_pkg::CSR_ESTAT;
    csr_list[5]  = csr_pkg::CSR_ERA;
    csr_list[6]  = csr_pkg::CSR_BADV;
    csr_list[7]  = csr_pkg::CSR_EENTRY;
    csr_list[8]  = csr_pkg::CSR_SAVE0;
    csr_list[9]  = csr_pkg::CSR_SAVE1;
    csr_list[10] = csr_pkg::CSR_SAVE2;
    csr_list[11] = csr_pkg::CSR_SAVE3;
    csr_list[12] = csr_pkg::CSR_TID;
    csr_list[13] = csr_pkg::CSR_TCFG;
    csr_list[14] = csr_pkg::CSR_TVAL;
    csr_list[15] = csr_pkg::CSR_TICLR;
  endtask

  // One write attempt, qualifiers given by the caller
  task automatic write_csr(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t mask,
                           input csr_pkg::csr_data_t data, input logic wr_commit,
                           input logic wr_valid, input logic wr_stall);
    we     = 1'b1;
    commit = wr_commit;
    valid  = wr_valid;
    stall  = wr_stall;
    w_addr = addr;
    w_mask = mask;
    w_data = data;
    next_cycle();
    we     = 1'b0;
    commit = 1'b0;
    valid  = 1'b0;
    stall  = 1'b0;
  endtask

  task automatic read_csr(input csr_pkg::csr_addr_t addr, output csr_pkg::csr_data_t data);
    r_addr = addr;
    rdcnt  = csr_pkg::RDCNT_NONE;
    next_cycle();
    data = r_data;  // Captured at the edge just passed
  endtask

`include "tb_csr_tasks.svh"

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Run timed out before all tests completed");
    $display("Finished with errors");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    seed        = 32917;
    error_count = 0;
    rst_n  = 1'b0;
    stall  = 1'b0;
    we     = 1'b0;
    commit = 1'b0;
    valid  = 1'b0;
    w_addr = '0;
    r_addr = '0;
    w_mask = '0;
    w_data = '0;
    rdcnt  = csr_pkg::RDCNT_NONE;
    load_csr_list();
    for (int i = 0; i < csr_pkg::NUM_CSR; i++) begin
      model[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    reset_values_read_zero();
    write_readback();
    masked_write();
    stall_holds_read();
    counter_reads();

    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+include
hw/csr_pkg.sv
hw/csr_reg_bank.sv
hw/stable_counter.sv
hw/csr_read_select.sv
hw/csr_unit.sv
testbench/tb_csr_unit.sv
